// File: baud_timer.sv
// Bit-period timer for the serial PHY.
// Counts system clocks while run is high and sits at zero otherwise,
// giving a mid-bit and an end-of-bit pulse in every bit period.
`timescale 1ns/1ps
`default_nettype none

module baud_timer
	import str_uart_pkg::*;
(
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  run,
	output logic tick,
	output logic half_tick
);

	logic [15:0] count;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			count <= '0;
		end else if (!run || count == BAUD_DIV - 16'd1) begin
			count <= '0;  // Restart on every new bit and whenever stopped.
		end else begin
			count <= count + 16'd1;
		end
	end

	assign tick      = run && (count == BAUD_DIV - 16'd1);
	assign half_tick = run && (count == (BAUD_DIV >> 1) - 16'd1);

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) count < BAUD_DIV)
		else $error("baud_timer count ran past the bit period");

endmodule

`default_nettype wire

// File: byte_link_if.sv
// Byte-level link between the string framer and the serial PHY.
// The framer offers one byte at a time with tx_start and waits for tx_done;
// the PHY hands up each received byte with a one-cycle rx_valid.
`timescale 1ns/1ps
`default_nettype none

interface byte_link_if;

	logic [7:0] tx_data;   // Byte to send, valid with tx_start.
	logic       tx_start;  // Only pulsed while tx_busy is low.
	logic       tx_busy;
	logic       tx_done;   // Pulses as tx_busy falls.
	logic [7:0] rx_data;
	logic       rx_valid;  // Stop bit was good.

	modport framer (
		output tx_data,
		output tx_start,
		input  tx_busy,
		input  tx_done,
		input  rx_data,
		input  rx_valid
	);

	modport phy (
		input  tx_data,
		input  tx_start,
		output tx_busy,
		output tx_done,
		output rx_data,
		output rx_valid
	);

endinterface

`default_nettype wire

// File: compile.f
str_uart_pkg.sv
byte_link_if.sv
baud_timer.sv
uart_phy.sv
string_framer.sv
uart_string_top.sv
tb_uart_string.sv

// File: run_sim.sh
#!/bin/sh
# Builds the UART string link testbench with Verilator and runs it.
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_uart_string -f compile.f -o sim_tb \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "Simulation failed"; exit 1; } || echo "Simulation passed"

// File: stim_input.txt
# op len data done exp_len exp_str exp_ovf ; T loopback, R raw line bytes, Z zero-length request
# data and exp_str in hex with byte 0 lowest; done is 1 when rx_done must pulse
T 5 4F4C4C4548 1 5 4F4C4C4548 0
T 16 46454443424139383736353433323130 1 16 46454443424139383736353433323130 0
T 1 5A 1 1 5A 0
Z 0 4142 0 1 5A 0

# Single marker inside a raw payload
R 9 262664632662612626 1 5 6463266261 0
# Noise and a lone marker, then a good frame
R 4 41265958 0 5 6463266261 0
R 6 26266B6F2626 1 2 6B6F 0

# Eighteen characters overflow the buffer, the next frame clears the flag
R 22 26267271706F6E6D6C6B6A6968676665646362612626 1 16 706F6E6D6C6B6A696867666564636261 1
T 3 7A7978 1 3 7A7978 0
T 3 622661 1 3 622661 0
Z 0 4344 0 3 622661 0

// File: str_uart_pkg.sv
// Constants shared by the UART string link.
// Import this package into any module that needs the link widths,
// the baud divisor, the frame delimiter or the framer state codes.
`default_nettype none

package str_uart_pkg;

	localparam logic [15:0] BAUD_DIV  = 16'd16;                 // System clocks per serial bit.
	localparam int          MAX_CHARS = 16;                     // Most characters in one string.
	localparam int          STR_W     = MAX_CHARS * 8;          // Character i sits at bit 8*i.
	localparam int          LEN_W     = $clog2(MAX_CHARS + 1);  // Holds 0 up to MAX_CHARS.
	localparam logic [7:0]  DELIM     = 8'h26;                  // The "&" frame marker.

	localparam logic [2:0] TX_IDLE    = 3'd0;
	localparam logic [2:0] TX_OPEN1   = 3'd1;  // First opening marker on the line.
	localparam logic [2:0] TX_OPEN2   = 3'd2;
	localparam logic [2:0] TX_PAYLOAD = 3'd3;
	localparam logic [2:0] TX_CLOSE1  = 3'd4;  // First closing marker on the line.
	localparam logic [2:0] TX_CLOSE2  = 3'd5;
	localparam logic [2:0] TX_FINISH  = 3'd6;

	localparam logic [2:0] RX_IDLE     = 3'd0;
	localparam logic [2:0] RX_OPEN1    = 3'd1;  // One opening marker seen.
	localparam logic [2:0] RX_PAYLOAD  = 3'd2;
	localparam logic [2:0] RX_AMP_SEEN = 3'd3;  // Marker inside payload, may close it.
	localparam logic [2:0] RX_FINISH   = 3'd4;

endpackage

`default_nettype wire

// File: string_framer.sv
// Frames strings as "&&" + payload + "&&" for the byte link and unframes
// received bytes back into a string buffer.
// The host pulses tx_req with a string and length, and reads rx_string
// and rx_length when rx_done pulses.
`timescale 1ns/1ps
`default_nettype none

module string_framer
	import str_uart_pkg::*;
(
	input  wire              sys_clk,
	input  wire              sys_rst_n,
	input  wire  [STR_W-1:0] tx_string,
	input  wire  [LEN_W-1:0] tx_length,
	input  wire              tx_req,
	output logic             tx_busy,
	output logic             tx_done,
	output logic [STR_W-1:0] rx_string,
	output logic [LEN_W-1:0] rx_length,
	output logic             rx_busy,
	output logic             rx_done,
	output logic             rx_overflow,
	byte_link_if.framer      link
);

	logic [2:0]       tx_state;
	logic [STR_W-1:0] tx_buf;
	logic [LEN_W-1:0] tx_len;
	logic [LEN_W-1:0] tx_cnt;     // Next payload character to send.
	logic             tx_accept;

	logic [2:0]       rx_state;
	logic             rx_byte;    // A received byte that is not a marker.
	logic             rx_room1;
	logic             rx_room2;

	// Finish behaves like idle, so a new request can follow the done pulse.
	assign tx_accept = tx_req && (tx_length != '0) && !link.tx_busy &&
		((tx_state == TX_IDLE) || (tx_state == TX_FINISH));
	assign tx_busy = (tx_state != TX_IDLE) && (tx_state != TX_FINISH);
	assign tx_done = (tx_state == TX_FINISH);

	always_ff @(posedge sys_clk) begin
		if (tx_accept) begin
			tx_buf <= tx_string;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state      <= TX_IDLE;
			tx_len        <= '0;
			tx_cnt        <= '0;
			link.tx_start <= 1'b0;
			link.tx_data  <= '0;
		end else begin
			link.tx_start <= 1'b0;
			case (tx_state)
				TX_IDLE, TX_FINISH: begin
					if (tx_accept) begin
						tx_len        <= (tx_length > LEN_W'(MAX_CHARS)) ? LEN_W'(MAX_CHARS) : tx_length;
						tx_cnt        <= '0;
						link.tx_data  <= DELIM;
						link.tx_start <= 1'b1;
						tx_state      <= TX_OPEN1;
					end else begin
						tx_state <= TX_IDLE;
					end
				end
				TX_OPEN1: begin
					if (link.tx_done) begin
						link.tx_data  <= DELIM;
						link.tx_start <= 1'b1;
						tx_state      <= TX_OPEN2;
					end
				end
				TX_OPEN2: begin
					if (link.tx_done) begin
						link.tx_data  <= tx_buf[7:0];
						link.tx_start <= 1'b1;
						tx_cnt        <= LEN_W'(1);
						tx_state      <= TX_PAYLOAD;
					end
				end
				TX_PAYLOAD: begin
					if (link.tx_done) begin
						link.tx_start <= 1'b1;
						if (tx_cnt == tx_len) begin
							link.tx_data <= DELIM;  // Payload done, start the closing pair.
							tx_state     <= TX_CLOSE1;
						end else begin
							link.tx_data <= tx_buf[8*tx_cnt +: 8];
							tx_cnt       <= tx_cnt + LEN_W'(1);
						end
					end
				end
				TX_CLOSE1: begin
					if (link.tx_done) begin
						link.tx_data  <= DELIM;
						link.tx_start <= 1'b1;
						tx_state      <= TX_CLOSE2;
					end
				end
				TX_CLOSE2: begin
					if (link.tx_done) begin
						tx_state <= TX_FINISH;
					end
				end
				default: tx_state <= TX_IDLE;
			endcase
		end
	end

	assign rx_busy  = (rx_state != RX_IDLE);
	assign rx_done  = (rx_state == RX_FINISH);
	assign rx_byte  = link.rx_valid && (link.rx_data != DELIM);
	assign rx_room1 = rx_length < LEN_W'(MAX_CHARS);
	assign rx_room2 = rx_length < LEN_W'(MAX_CHARS - 1);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state    <= RX_IDLE;
			rx_length   <= '0;
			rx_overflow <= 1'b0;
		end else if (link.rx_valid || rx_state == RX_FINISH) begin
			case (rx_state)
				RX_IDLE: begin
					if (!rx_byte) begin
						rx_state <= RX_OPEN1;
					end
				end
				RX_OPEN1: begin
					if (rx_byte) begin
						rx_state <= RX_IDLE;  // Lone marker, not a frame start.
					end else begin
						rx_length   <= '0;
						rx_overflow <= 1'b0;
						rx_state    <= RX_PAYLOAD;
					end
				end
				RX_PAYLOAD: begin
					if (!rx_byte) begin
						rx_state <= RX_AMP_SEEN;
					end else if (rx_room1) begin
						rx_length <= rx_length + LEN_W'(1);
					end else begin
						rx_overflow <= 1'b1;
					end
				end
				RX_AMP_SEEN: begin
					if (!rx_byte) begin
						rx_state <= RX_FINISH;
					end else begin
						rx_state <= RX_PAYLOAD;
						if (rx_room2) begin
							rx_length <= rx_length + LEN_W'(2);  // Keep the marker and the byte.
						end else if (rx_room1) begin
							rx_length   <= rx_length + LEN_W'(1);
							rx_overflow <= 1'b1;
						end else begin
							rx_overflow <= 1'b1;
						end
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_byte && rx_state == RX_PAYLOAD && rx_room1) begin
			rx_string[8*rx_length +: 8] <= link.rx_data;
		end
		if (rx_byte && rx_state == RX_AMP_SEEN && rx_room1) begin
			rx_string[8*rx_length +: 8] <= DELIM;
		end
		if (rx_byte && rx_state == RX_AMP_SEEN && rx_room2) begin
			rx_string[8*rx_length + 8 +: 8] <= link.rx_data;
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= LEN_W'(MAX_CHARS))
		else $error("rx_length grew past the string buffer");

endmodule

`default_nettype wire

// File: tb_uart_string.sv
// Self-checking testbench for the UART string link.
// Reads vectors from stim_input.txt, sends strings in loopback or drives raw
// bytes on the serial input, and checks the received string, the framing on
// uart_tx_port and the request and done handshakes.
`timescale 1ns/1ps
`default_nettype none

module tb_uart_string
	import str_uart_pkg::*;
;

	logic             sys_clk;
	logic             sys_rst_n;
	logic [STR_W-1:0] tx_string;
	logic [LEN_W-1:0] tx_length;
	logic             tx_req;
	logic             tx_busy;
	logic             tx_done;
	logic [STR_W-1:0] rx_string;
	logic [LEN_W-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             rx_overflow;
	logic             uart_tx_port;
	logic             serial_line;
	logic             drv_line;     // Serial driver output for raw bytes.
	logic             loopback;     // High routes uart_tx_port back to the receiver.

	logic [7:0]   vec_op [$];
	int           vec_len [$];
	logic [255:0] vec_data [$];
	int           vec_done [$];
	int           vec_exp_len [$];
	logic [255:0] vec_exp_str [$];
	int           vec_exp_ovf [$];
	logic [7:0]   expect_q [$];      // Bytes still due on uart_tx_port.
	int           error_count = 0;
	int           check_count = 0;
	int           tx_done_count = 0;
	int           rx_done_count = 0;
	int           watchdog_ns;
	bit           vectors_loaded = 1'b0;
	bit           rx_busy_seen = 1'b0;  // Set once rx_busy is high within a vector.

	assign serial_line = loopback ? uart_tx_port : drv_line;

	uart_string_top u_uart_string_top (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_string    (tx_string),
		.tx_length    (tx_length),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_overflow  (rx_overflow),
		.uart_rx_port (serial_line),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Done strobes are one cycle long, so a count per rising edge catches each.
	always @(posedge sys_clk) begin
		if (tx_done === 1'b1) tx_done_count <= tx_done_count + 1;
		if (rx_done === 1'b1) rx_done_count <= rx_done_count + 1;
		if (rx_busy === 1'b1) rx_busy_seen <= 1'b1;
	end

	task automatic check_equal(input logic [255:0] got, input logic [255:0] exp,
		input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [255:0] length_mask(input int len);
		logic [255:0] m;
		m = '0;
		for (int i = 0; i < 8 * len; i++) m[i] = 1'b1;
		return m;
	endfunction

	task automatic load_vectors();
		int           fd;
		int           n;
		string        line;
		logic [7:0]   op;
		int           len, done, exp_len, exp_ovf;
		logic [255:0] data, exp_str;
		fd = $fopen("stim_input.txt", "r");
		if (fd == 0) begin
			$display("Could not open stim_input.txt, no vectors were run");
			error_count++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 3 || line[0] == "#") continue;  // Comments and blanks.
				n = $sscanf(line, "%c %d %h %d %d %h %d", op, len, data, done, exp_len,
					exp_str, exp_ovf);
				if (n != 7) begin
					$display("Malformed vector line in stim_input.txt: %s", line);
					error_count++;
				end else begin
					vec_op.push_back(op);
					vec_len.push_back(len);
					vec_data.push_back(data);
					vec_done.push_back(done);
					vec_exp_len.push_back(exp_len);
					vec_exp_str.push_back(exp_str);
					vec_exp_ovf.push_back(exp_ovf);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_serial_byte(input logic [7:0] value);
		drv_line = 1'b0;  // Start bit.
		repeat (BAUD_DIV) @(negedge sys_clk);
		for (int b = 0; b < 8; b++) begin
			drv_line = value[b];
			repeat (BAUD_DIV) @(negedge sys_clk);
		end
		drv_line = 1'b1;
		repeat (BAUD_DIV) @(negedge sys_clk);
	endtask

	task automatic send_string(input int idx);
		int start_done;
		start_done = tx_done_count;
		expect_q.push_back(DELIM);
		expect_q.push_back(DELIM);
		for (int i = 0; i < vec_len[idx]; i++) expect_q.push_back(vec_data[idx][8*i +: 8]);
		expect_q.push_back(DELIM);
		expect_q.push_back(DELIM);
		tx_string = vec_data[idx][STR_W-1:0];
		tx_length = LEN_W'(vec_len[idx]);
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		check_equal(256'(tx_busy), 256'(1), "tx_busy one cycle after tx_req");
		check_equal(256'(uart_tx_port), 256'(1), "uart_tx_port one cycle after tx_req");
		@(negedge sys_clk);
		check_equal(256'(uart_tx_port), 256'(0), "start bit in second cycle after tx_req");
		tx_string = ~tx_string;  // A request while busy must leave the frame alone.
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		while (tx_done !== 1'b1) begin
			check_equal(256'(tx_busy), 256'(1), "tx_busy during the frame");
			@(negedge sys_clk);
		end
		check_equal(256'(tx_busy), 256'(0), "tx_busy in the tx_done cycle");
		@(negedge sys_clk);
		check_equal(256'(tx_done_count), 256'(start_done + 1), "tx_done pulses per frame");
	endtask

	task automatic send_empty_request(input int idx);
		int start_done;
		start_done = tx_done_count;
		tx_string = vec_data[idx][STR_W-1:0];
		tx_length = '0;
		tx_req    = 1'b1;
		@(negedge sys_clk);
		tx_req = 1'b0;
		repeat (2 * int'(BAUD_DIV)) begin
			check_equal(256'(uart_tx_port), 256'(1), "uart_tx_port after empty request");
			check_equal(256'(tx_busy), 256'(0), "tx_busy after empty request");
			@(negedge sys_clk);
		end
		check_equal(256'(tx_done_count), 256'(start_done), "tx_done after empty request");
	endtask

	task automatic wait_rx_done(input int target);
		int waited;
		waited = 0;
		while (rx_done_count < target && waited < 40 * int'(BAUD_DIV)) begin
			@(negedge sys_clk);
			waited++;
		end
		if (rx_done_count < target) begin
			$display("rx_done never arrived after the frame at %0t ns", $time);
			error_count++;
		end
	endtask

	task automatic run_vector(input int idx);
		int start_rx;
		start_rx = rx_done_count;
		rx_busy_seen = 1'b0;
		loopback = (vec_op[idx] != "R");
		case (vec_op[idx])
			"T": send_string(idx);
			"Z": send_empty_request(idx);
			"R": for (int i = 0; i < vec_len[idx]; i++) drive_serial_byte(vec_data[idx][8*i +: 8]);
			default: begin
				$display("Vector %0d has an unknown operation %c", idx, vec_op[idx]);
				error_count++;
			end
		endcase
		if (vec_done[idx] != 0) wait_rx_done(start_rx + 1);
		else repeat (2 * int'(BAUD_DIV)) @(negedge sys_clk);  // Line idles, nothing may arrive.
		check_equal(256'(rx_done_count), 256'(start_rx + vec_done[idx]), "rx_done pulses");
		if (vec_done[idx] != 0) begin
			check_equal(256'(rx_busy_seen), 256'(1), "rx_busy during the received frame");
		end
		check_equal(256'(rx_busy), 256'(0), "rx_busy after the vector");
		check_equal(256'(rx_length), 256'(vec_exp_len[idx]), "rx_length");
		check_equal(256'(rx_string) & length_mask(vec_exp_len[idx]), vec_exp_str[idx], "rx_string");
		check_equal(256'(rx_overflow), 256'(vec_exp_ovf[idx]), "rx_overflow");
	endtask

	// Decodes uart_tx_port and checks that each bit holds for a whole bit period.
	initial begin : tx_line_monitor
		logic [9:0] bits;
		logic [7:0] got_byte;
		logic [7:0] exp_byte;
		logic       level;
		wait (sys_rst_n === 1'b1);
		forever begin
			@(negedge sys_clk);
			if (uart_tx_port === 1'b0) begin
				for (int b = 0; b < 10; b++) begin
					if (b != 0) @(negedge sys_clk);
					level   = uart_tx_port;
					bits[b] = level;
					for (int c = 1; c < int'(BAUD_DIV); c++) begin
						@(negedge sys_clk);
						check_equal(256'(uart_tx_port), 256'(level), "uart_tx_port within a bit");
					end
				end
				check_equal(256'(bits[9]), 256'(1), "stop bit on uart_tx_port");
				got_byte = bits[8:1];
				if (expect_q.size() == 0) begin
					$display("Unexpected byte %0h on uart_tx_port at %0t ns", got_byte, $time);
					error_count++;
				end else begin
					exp_byte = expect_q.pop_front();
					check_equal(256'(got_byte), 256'(exp_byte), "byte on uart_tx_port");
				end
			end
		end
	end

	initial begin : watchdog
		wait (vectors_loaded);
		watchdog_ns = (vec_op.size() + 1) * (MAX_CHARS + 6) * 10 * int'(BAUD_DIV) * 8 * 2;
		#(watchdog_ns);
		$display("Timeout: the vectors did not finish within %0d ns", watchdog_ns);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		sys_rst_n = 1'b0;
		tx_string = '0;
		tx_length = '0;
		tx_req    = 1'b0;
		drv_line  = 1'b1;
		loopback  = 1'b1;
		load_vectors();
		vectors_loaded = 1'b1;
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		@(negedge sys_clk);
		check_equal(256'({tx_busy, tx_done, rx_busy, rx_done, rx_overflow}), 256'(0),
			"status flags after reset");
		check_equal(256'(uart_tx_port), 256'(1), "uart_tx_port after reset");
		check_equal(256'(rx_length), 256'(0), "rx_length after reset");
		for (int idx = 0; idx < vec_op.size(); idx++) run_vector(idx);
		check_equal(256'(expect_q.size()), 256'(0), "bytes still due on uart_tx_port");
		$display("Vectors: %0d, checks: %0d, errors: %0d", vec_op.size(), check_count,
			error_count);
		if (error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: uart_phy.sv
// 8N1 serial PHY with one baud timer per direction.
// Transmit shifts out start, eight data bits LSB first and one stop bit;
// receive synchronizes the line, samples mid-bit and reports good bytes.
`timescale 1ns/1ps
`default_nettype none

module uart_phy (
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	byte_link_if.phy  link,
	input  wire       serial_in,
	output logic      serial_out
);

	logic [9:0] tx_shift;    // Stop, data and start bits, LSB goes out first.
	logic [3:0] tx_bit_cnt;
	logic       tx_tick;

	logic [2:0] rx_sync;     // Two sync flops plus one for edge detect.
	logic       rx_line;
	logic       rx_fall;
	logic       rx_active;
	logic [3:0] rx_bit_cnt;
	logic [7:0] rx_shift;
	logic       rx_half;

	baud_timer u_tx_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (link.tx_busy),
		.tick      (tx_tick),
		.half_tick ()
	);

	baud_timer u_rx_timer (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.run       (rx_active),
		.tick      (),
		.half_tick (rx_half)
	);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_shift     <= '1;  // Line idles high.
			tx_bit_cnt   <= '0;
			link.tx_busy <= 1'b0;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (link.tx_start && !link.tx_busy) begin
				tx_shift     <= {1'b1, link.tx_data, 1'b0};
				tx_bit_cnt   <= '0;
				link.tx_busy <= 1'b1;
			end else if (link.tx_busy && tx_tick) begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				if (tx_bit_cnt == 4'd9) begin
					link.tx_busy <= 1'b0;  // Stop bit has run its full period.
					link.tx_done <= 1'b1;
				end else begin
					tx_bit_cnt <= tx_bit_cnt + 4'd1;
				end
			end
		end
	end

	assign serial_out = tx_shift[0];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_sync <= '1;
		end else begin
			rx_sync <= {rx_sync[1:0], serial_in};
		end
	end

	assign rx_line = rx_sync[1];
	assign rx_fall = rx_sync[2] && !rx_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_active     <= 1'b0;
			rx_bit_cnt    <= '0;
			link.rx_valid <= 1'b0;
		end else begin
			link.rx_valid <= 1'b0;
			if (!rx_active) begin
				if (rx_fall) begin
					rx_active  <= 1'b1;
					rx_bit_cnt <= '0;
				end
			end else if (rx_half) begin
				rx_bit_cnt <= rx_bit_cnt + 4'd1;
				if (rx_bit_cnt == 4'd0 && rx_line) begin
					rx_active <= 1'b0;  // Glitch, start bit gone by mid-bit.
				end else if (rx_bit_cnt == 4'd9) begin
					rx_active     <= 1'b0;
					link.rx_valid <= rx_line;  // Framing error drops the byte.
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_active && rx_half && rx_bit_cnt != 4'd0 && rx_bit_cnt != 4'd9) begin
			rx_shift <= {rx_line, rx_shift[7:1]};
		end
	end

	assign link.rx_data = rx_shift;

	// The framer must wait for the PHY to finish each byte.
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		link.tx_start |-> !link.tx_busy)
		else $error("tx_start arrived while the PHY was still sending");

endmodule

`default_nettype wire

// File: uart_string_top.sv
// Top level of the UART string link.
// Hosts drive tx_string, tx_length and tx_req and read the received
// string on rx_string and rx_length when rx_done pulses.
// uart_tx_port and uart_rx_port go to the serial line.
`timescale 1ns/1ps
`default_nettype none

module uart_string_top
	import str_uart_pkg::*;
(
	input  wire              sys_clk,
	input  wire              sys_rst_n,
	input  wire  [STR_W-1:0] tx_string,
	input  wire  [LEN_W-1:0] tx_length,
	input  wire              tx_req,
	output logic             tx_busy,
	output logic             tx_done,
	output logic [STR_W-1:0] rx_string,
	output logic [LEN_W-1:0] rx_length,
	output logic             rx_busy,
	output logic             rx_done,
	output logic             rx_overflow,
	input  wire              uart_rx_port,
	output logic             uart_tx_port
);

	byte_link_if u_link ();

	string_framer u_framer (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.tx_string   (tx_string),
		.tx_length   (tx_length),
		.tx_req      (tx_req),
		.tx_busy     (tx_busy),
		.tx_done     (tx_done),
		.rx_string   (rx_string),
		.rx_length   (rx_length),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_overflow (rx_overflow),
		.link        (u_link.framer)
	);

	uart_phy u_phy (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.link       (u_link.phy),
		.serial_in  (uart_rx_port),
		.serial_out (uart_tx_port)
	);

endmodule

`default_nettype wire
